// ==== hw/lawnPkg.sv ====
`default_nettype none

package lawnPkg;

	// Pixel coordinates and zombie columns
	localparam int coordWidth = 10;
	typedef logic [coordWidth-1:0] coordT;

	// Four bits per channel in red, green, blue order
	typedef logic [11:0] rgbT;

	localparam int laneCount = 5;

	// One-hot plant choice
	typedef logic [2:0] plantT;

	typedef enum logic [1:0] {
		gamePlaying,
		gameWon,
		gameLost
	} gameStateT;

	// Lane behaviour
	localparam int hitsToKill = 5;
	localparam int laneStartStep = 4;
	localparam coordT lawnStartX = 10'd799;
	localparam coordT lawnEndX = 10'd0;

	// Screen geometry
	localparam coordT topBarHeight = 10'd160;
	localparam coordT laneHeight = 10'd128;
	localparam coordT bodyInset = 10'd5;
	localparam coordT bodyWidth = 10'd100;
	localparam coordT gridCell = 10'd160;
	localparam coordT frameWidth = 10'd5;

	// Plant boxes in the top bar
	localparam coordT plantBoxWidth = 10'd160;
	localparam int plantBoxCount = 3;
	localparam plantT plantPea = 3'b001;
	localparam plantT plantSun = 3'b010;
	localparam plantT plantNut = 3'b100;

	// Palette
	localparam rgbT colBlack = 12'b0000_0000_0000;
	localparam rgbT colGrey = 12'b0000_1011_0100;
	localparam rgbT colGreen = 12'b0000_1111_0000;
	localparam rgbT colDarkGreen = 12'b0011_1001_0010;
	localparam rgbT colRed = 12'b1111_0000_0000;
	localparam rgbT colZombie = 12'b1010_1010_1011;

endpackage

`default_nettype wire

// ==== hw/gameTicker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameTicker #(
	parameter int tickDivide = 500000
) (
	input wire clk,
	input wire rstN,
	input wire [lawnPkg::laneCount-1:0] killed,
	input wire lawnPkg::coordT [lawnPkg::laneCount-1:0] zombieX,
	output logic tick,
	output logic [15:0] killCount,
	output lawnPkg::gameStateT gameState
);
	import lawnPkg::*;

	localparam int divWidth = $clog2(tickDivide);
	localparam logic [divWidth-1:0] divLast = divWidth'(tickDivide - 1);

	logic [divWidth-1:0] divCount;
	logic tickPulse;
	logic [laneCount-1:0] killedPrev;
	logic [laneCount-1:0] newKills;
	logic allKilled;
	logic anyReached;

	// Number of lanes that died since the last cycle
	function automatic logic [2:0] countKills(input logic [laneCount-1:0] rise);
		logic [2:0] total;
		total = '0;
		for (int i = 0; i < laneCount; i++)
			total = total + 3'(rise[i]);
		return total;
	endfunction

	// Clock divider for the game tick
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			divCount <= '0;
			tickPulse <= 1'b0;
		end
		else if (divCount == divLast)
		begin
			divCount <= '0;
			tickPulse <= 1'b1;
		end
		else
		begin
			divCount <= divCount + 1'b1;
			tickPulse <= 1'b0;
		end
	end

	// Nothing moves once the round is decided
	assign tick = tickPulse && (gameState == gamePlaying);

	assign newKills = killed & ~killedPrev;

	always_comb
	begin
		allKilled = &killed;
		anyReached = 1'b0;
		// Only a living zombie at the house ends the round
		for (int i = 0; i < laneCount; i++)
			if (!killed[i] && zombieX[i] == lawnEndX)
				anyReached = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			killedPrev <= '0;
			killCount <= '0;
			gameState <= gamePlaying;
		end
		else
		begin
			killedPrev <= killed;
			killCount <= killCount + 16'(countKills(newKills));
			// Win is checked first
			if (gameState == gamePlaying)
			begin
				if (allKilled)
					gameState <= gameWon;
				else if (anyReached)
					gameState <= gameLost;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/zombieLane.sv ====
`timescale 1ns/1ps
`default_nettype none

module zombieLane #(
	parameter int laneIndex = 0
) (
	input wire clk,
	input wire rstN,
	input wire tick,
	input wire peaValid,
	input wire lawnPkg::coordT peaX,
	output lawnPkg::coordT zombieX,
	output logic killed
);
	import lawnPkg::*;

	// Later lanes wait longer before walking
	localparam int startDelay = (laneIndex + 1) * laneStartStep;
	localparam int delayWidth = $clog2(startDelay + 1);
	localparam int hitWidth = $clog2(hitsToKill + 1);

	logic [delayWidth-1:0] delayCount;
	logic [hitWidth-1:0] hitCount;
	logic delayDone;
	logic peaHit;
	logic lastHit;

	assign delayDone = (delayCount == delayWidth'(startDelay));

	// A pea at or past the zombie counts as a hit
	assign peaHit = peaValid && (peaX >= zombieX);
	assign lastHit = peaHit && (hitCount == hitWidth'(hitsToKill - 1));

	// Hit tally and kill flag
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			hitCount <= '0;
			killed <= 1'b0;
		end
		else if (tick && !killed)
		begin
			if (peaHit)
				hitCount <= hitCount + 1'b1;
			if (lastHit)
				killed <= 1'b1;
		end
	end

	// Start delay, then one column left per tick
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			delayCount <= '0;
			zombieX <= lawnStartX;
		end
		else if (tick && !killed)
		begin
			if (!delayDone)
				delayCount <= delayCount + 1'b1;
			else if (!lastHit && zombieX != lawnEndX)
				zombieX <= zombieX - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/plantSelector.sv ====
`timescale 1ns/1ps
`default_nettype none

module plantSelector (
	input wire clk,
	input wire rstN,
	input wire leftButton,
	input wire rightButton,
	input wire selectButton,
	output lawnPkg::coordT cursorX,
	output logic choosing,
	output lawnPkg::plantT plantChoice
);
	import lawnPkg::*;

	// Left edge of the last plant box
	localparam coordT cursorMax = coordT'((plantBoxCount - 1) * plantBoxWidth);

	logic leftPrev;
	logic rightPrev;
	logic selectPrev;
	logic leftRise;
	logic rightRise;
	logic selectRise;

	// Held buttons only act on their first cycle
	assign leftRise = leftButton && !leftPrev;
	assign rightRise = rightButton && !rightPrev;
	assign selectRise = selectButton && !selectPrev;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			leftPrev <= 1'b0;
			rightPrev <= 1'b0;
			selectPrev <= 1'b0;
			cursorX <= '0;
			choosing <= 1'b0;
			plantChoice <= '0;
		end
		else
		begin
			leftPrev <= leftButton;
			rightPrev <= rightButton;
			selectPrev <= selectButton;
			if (!choosing)
			begin
				if (selectRise)
				begin
					choosing <= 1'b1;
					cursorX <= '0;
				end
			end
			else if (selectRise)
			begin
				choosing <= 1'b0;
				if (cursorX == '0)
					plantChoice <= plantPea;
				else if (cursorX == plantBoxWidth)
					plantChoice <= plantSun;
				else
					plantChoice <= plantNut;
			end
			else if (leftRise)
				cursorX <= (cursorX >= plantBoxWidth) ? cursorX - plantBoxWidth : '0;
			else if (rightRise)
				cursorX <= (cursorX >= cursorMax) ? cursorMax : cursorX + plantBoxWidth;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lawnPainter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lawnPainter (
	input wire bright,
	input wire lawnPkg::coordT hCount,
	input wire lawnPkg::coordT vCount,
	input wire lawnPkg::coordT cursorX,
	input wire choosing,
	input wire lawnPkg::coordT [lawnPkg::laneCount-1:0] zombieX,
	input wire [lawnPkg::laneCount-1:0] killed,
	output lawnPkg::rgbT rgb
);
	import lawnPkg::*;

	logic inTopBar;
	logic inCursorBox;
	logic onFrame;
	logic [laneCount-1:0] bodyHit;
	coordT lawnRow;
	coordT gridRow;
	coordT gridCol;
	logic onGrid;

	assign inTopBar = (vCount < topBarHeight);

	// Box under the cursor spans the whole bar height
	assign inCursorBox = inTopBar
		&& (hCount >= cursorX)
		&& (hCount < cursorX + plantBoxWidth);

	assign onFrame = inCursorBox && (
		(hCount < cursorX + frameWidth)
		|| (hCount >= cursorX + plantBoxWidth - frameWidth)
		|| (vCount < frameWidth)
		|| (vCount >= topBarHeight - frameWidth));

	// One body per lane, trimmed top and bottom
	for (genvar i = 0; i < laneCount; i++)
	begin : genBody
		localparam coordT laneTop = coordT'(topBarHeight + i * laneHeight);

		assign bodyHit[i] = !killed[i]
			&& (vCount >= laneTop + bodyInset)
			&& (vCount < laneTop + laneHeight - bodyInset)
			&& (hCount >= zombieX[i])
			&& (hCount < zombieX[i] + bodyWidth);
	end

	// Checkerboard counted from the top of the lawn
	assign lawnRow = vCount - topBarHeight;
	assign gridRow = lawnRow / gridCell;
	assign gridCol = hCount / gridCell;
	assign onGrid = !gridRow[0] && !gridCol[0];

	always_comb
	begin
		if (!bright)
			rgb = colBlack;
		else if (choosing && onFrame)
			rgb = colRed;
		else if (inTopBar)
			rgb = colGrey;
		else if (|bodyHit)
			rgb = colZombie;
		else if (onGrid)
			rgb = colDarkGreen;
		else
			rgb = colGreen;
	end

endmodule

`default_nettype wire

// ==== hw/lawnGame.sv ====
`timescale 1ns/1ps
`default_nettype none

module lawnGame #(
	parameter int tickDivide = 500000
) (
	input wire clk,
	input wire rstN,
	input wire bright,
	input wire lawnPkg::coordT hCount,
	input wire lawnPkg::coordT vCount,
	input wire leftButton,
	input wire rightButton,
	input wire selectButton,
	input wire [lawnPkg::laneCount-1:0] peaValid,
	input wire lawnPkg::coordT [lawnPkg::laneCount-1:0] peaX,
	output lawnPkg::rgbT rgb,
	output logic [15:0] killCount,
	output lawnPkg::gameStateT gameState,
	output logic choosing,
	output lawnPkg::plantT plantChoice
);
	import lawnPkg::*;

	logic tick;
	coordT [laneCount-1:0] zombieX;
	logic [laneCount-1:0] killed;
	coordT cursorX;

	gameTicker #(
		.tickDivide(tickDivide)
	) u_gameTicker (
		.clk(clk),
		.rstN(rstN),
		.killed(killed),
		.zombieX(zombieX),
		.tick(tick),
		.killCount(killCount),
		.gameState(gameState)
	);

	// Each lane sees only its own pea
	for (genvar i = 0; i < laneCount; i++)
	begin : genLane
		zombieLane #(
			.laneIndex(i)
		) u_zombieLane (
			.clk(clk),
			.rstN(rstN),
			.tick(tick),
			.peaValid(peaValid[i]),
			.peaX(peaX[i]),
			.zombieX(zombieX[i]),
			.killed(killed[i])
		);
	end

	plantSelector u_plantSelector (
		.clk(clk),
		.rstN(rstN),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.selectButton(selectButton),
		.cursorX(cursorX),
		.choosing(choosing),
		.plantChoice(plantChoice)
	);

	lawnPainter u_lawnPainter (
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.cursorX(cursorX),
		.choosing(choosing),
		.zombieX(zombieX),
		.killed(killed),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Release away from the active edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/lawnChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lawnChecker (
	input wire clk,
	input wire checkEn,
	input wire [2:0] checkField,
	input wire [15:0] expValue,
	input wire [127:0] testName,
	input wire lawnPkg::rgbT rgb,
	input wire [15:0] killCount,
	input wire lawnPkg::gameStateT gameState,
	input wire choosing,
	input wire lawnPkg::plantT plantChoice,
	output int checkCount,
	output int errorCount
);
	import lawnPkg::*;

	logic [15:0] actual;

	function automatic string fieldLabel(input logic [2:0] field);
		case (field)
			3'd0: return "killCount";
			3'd1: return "gameState";
			3'd2: return "choosing";
			3'd3: return "plantChoice";
			default: return "rgb";
		endcase
	endfunction

	// Output under test, selected by the field code
	always_comb
	begin
		case (checkField)
			3'd0: actual = killCount;
			3'd1: actual = 16'(gameState);
			3'd2: actual = 16'(choosing);
			3'd3: actual = 16'(plantChoice);
			default: actual = 16'(rgb);
		endcase
	end

	initial
	begin
		checkCount = 0;
		errorCount = 0;
	end

	// Values seen here are the ones held before this edge
	always @(posedge clk)
	begin
		if (checkEn)
		begin
			checkCount <= checkCount + 1;
			if (actual !== expValue)
			begin
				errorCount <= errorCount + 1;
				$display("** Error [%0s] %0s: expected %h, actual %h at %0t",
					testName, fieldLabel(checkField), expValue, actual, $time);
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/lawnGameTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lawnGameTb;
	import lawnPkg::*;

	localparam int tickDivide = 4;
	localparam int clockPeriod = 4;
	localparam int roundTime = (lawnStartX + 6 * laneStartStep + 50) * tickDivide * clockPeriod;
	localparam logic [2:0] fieldKills = 3'd0;
	localparam logic [2:0] fieldState = 3'd1;
	localparam logic [2:0] fieldChoosing = 3'd2;
	localparam logic [2:0] fieldChoice = 3'd3;
	localparam logic [2:0] fieldRgb = 3'd4;

	logic clk;
	logic rstN;
	logic testRstN;
	wire dutRstN;
	logic bright;
	coordT hCount;
	coordT vCount;
	logic leftButton;
	logic rightButton;
	logic selectButton;
	logic [laneCount-1:0] peaValid;
	coordT [laneCount-1:0] peaX;
	rgbT rgb;
	logic [15:0] killCount;
	gameStateT gameState;
	logic choosing;
	plantT plantChoice;
	logic checkEn;
	logic [2:0] checkField;
	logic [15:0] expValue;
	logic [127:0] testName;
	int checkCount;
	int errorCount;
	int timeLimit;

	// Pattern table with eight numeric fields per record
	logic [127:0] patName[$];
	logic [127:0] patKind[$];
	logic [127:0] patKeys[$];
	logic [15:0] patField[$];

	assign dutRstN = rstN && testRstN;

	clockGen u_clockGen (
		.clk(clk),
		.rstN(rstN)
	);

	lawnGame #(
		.tickDivide(tickDivide)
	) u_lawnGame (
		.clk(clk),
		.rstN(dutRstN),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.selectButton(selectButton),
		.peaValid(peaValid),
		.peaX(peaX),
		.rgb(rgb),
		.killCount(killCount),
		.gameState(gameState),
		.choosing(choosing),
		.plantChoice(plantChoice)
	);

	lawnChecker u_lawnChecker (
		.clk(clk),
		.checkEn(checkEn),
		.checkField(checkField),
		.expValue(expValue),
		.testName(testName),
		.rgb(rgb),
		.killCount(killCount),
		.gameState(gameState),
		.choosing(choosing),
		.plantChoice(plantChoice),
		.checkCount(checkCount),
		.errorCount(errorCount)
	);

	task automatic loadPatterns();
		int fd;
		int got;
		string line;
		logic [127:0] nameBits;
		logic [127:0] kindBits;
		logic [127:0] keyBits;
		logic [15:0] f [8];
		fd = $fopen("dv/lawnPatterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file dv/lawnPatterns.txt");
		end
		else
		begin
			while ($fgets(line, fd))
			begin
				if (line.len() > 1 && line[0] != "#")
				begin
					got = $sscanf(line, "%s %s %s %h %h %h %h %h %h %h %h", nameBits, kindBits,
						keyBits, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
					if (got == 11)
					begin
						patName.push_back(nameBits);
						patKind.push_back(kindBits);
						patKeys.push_back(keyBits);
						for (int k = 0; k < 8; k++)
							patField.push_back(f[k]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One comparison at the next rising edge
	task automatic compareOutput(input logic [2:0] field, input logic [15:0] value);
		checkField = field;
		expValue = value;
		checkEn = 1'b1;
		@(negedge clk);
		checkEn = 1'b0;
	endtask

	task automatic restartDut();
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		leftButton = 1'b0;
		rightButton = 1'b0;
		selectButton = 1'b0;
		peaValid = '0;
		peaX = {laneCount{lawnStartX}};
		testRstN = 1'b0;
		repeat (2) @(negedge clk);
		testRstN = 1'b1;
	endtask

	task automatic showPixel(input logic [15:0] h, input logic [15:0] v, input logic [15:0] b);
		hCount = coordT'(h);
		vCount = coordT'(v);
		bright = b[0];
	endtask

	// S select, L left, R right; anything else is skipped
	task automatic pressButtons(input logic [127:0] keys);
		logic [7:0] key;
		int selects;
		int gap;
		selects = 0;
		for (int i = 15; i >= 0; i--)
		begin
			key = keys[i*8 +: 8];
			if (key == "S" || key == "L" || key == "R")
			begin
				// An odd number of selects leaves the box open
				if (selects % 2 == 1)
					compareOutput(fieldChoosing, 16'd1);
				selectButton = (key == "S");
				leftButton = (key == "L");
				rightButton = (key == "R");
				@(negedge clk);
				selectButton = 1'b0;
				leftButton = 1'b0;
				rightButton = 1'b0;
				if (key == "S")
					selects++;
				gap = 1 + int'($urandom % 3);
				repeat (gap) @(negedge clk);
			end
		end
	endtask

	task automatic runPattern(input int r);
		logic [127:0] kind;
		logic [15:0] f [8];
		kind = patKind[r];
		testName = patName[r];
		for (int k = 0; k < 8; k++)
			f[k] = patField[r*8+k];
		restartDut();
		if (kind == "reset")
		begin
			compareOutput(fieldKills, f[6]);
			compareOutput(fieldState, f[7]);
			compareOutput(fieldChoosing, 16'd0);
			compareOutput(fieldChoice, f[4]);
			showPixel(f[0], f[1], f[2]);
			compareOutput(fieldRgb, f[5]);
		end
		else if (kind == "select")
		begin
			pressButtons(patKeys[r]);
			compareOutput(fieldChoosing, 16'd0);
			compareOutput(fieldChoice, f[4]);
		end
		else if (kind == "pixel")
		begin
			pressButtons(patKeys[r]);
			showPixel(f[0], f[1], f[2]);
			compareOutput(fieldRgb, f[5]);
		end
		else
		begin
			peaValid = f[3][laneCount-1:0];
			while (gameState == gamePlaying)
				@(negedge clk);
			compareOutput(fieldState, f[7]);
			compareOutput(fieldKills, f[6]);
			showPixel(f[0], f[1], f[2]);
			compareOutput(fieldRgb, f[5]);
			// The outcome has to survive another twenty ticks
			repeat (20 * tickDivide) @(negedge clk);
			compareOutput(fieldState, f[7]);
			compareOutput(fieldKills, f[6]);
		end
	endtask

	initial
	begin
		testRstN = 1'b1;
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		leftButton = 1'b0;
		rightButton = 1'b0;
		selectButton = 1'b0;
		peaValid = '0;
		peaX = {laneCount{lawnStartX}};
		checkEn = 1'b0;
		checkField = '0;
		expValue = '0;
		testName = '0;
		timeLimit = 0;
		void'($urandom(52));
		loadPatterns();
		timeLimit = 2000 * patName.size() + 1000;
		foreach (patKind[i])
			if (patKind[i] == "game")
				timeLimit += roundTime;
		wait (rstN);
		@(negedge clk);
		for (int r = 0; r < patName.size(); r++)
			runPattern(r);
		@(negedge clk);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog sized from the pattern count and the game rounds
	initial
	begin
		wait (timeLimit != 0);
		#(timeLimit);
		$display("Timeout: test %0s did not finish within %0d ns", testName, timeLimit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== zombieLawn.f ====
hw/lawnPkg.sv
hw/gameTicker.sv
hw/zombieLane.sv
hw/plantSelector.sv
hw/lawnPainter.sv
hw/lawnGame.sv
dv/clockGen.sv
dv/lawnChecker.sv
dv/lawnGameTb.sv

// ==== Bender.yml ====
package:
  name: zombieLawn

sources:
  - hw/lawnPkg.sv
  - hw/gameTicker.sv
  - hw/zombieLane.sv
  - hw/plantSelector.sv
  - hw/lawnPainter.sv
  - hw/lawnGame.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/lawnChecker.sv
      - dv/lawnGameTb.sv

// ==== dv/lawnPatterns.txt ====
# name kind buttons hCount vCount bright peaMask plantChoice rgb killCount gameState
# numbers in hex; buttons S select, L left, R right, - none; state 0 playing 1 won 2 lost
resetState     reset  -     31F 0C8 1 00 0 AAB 0 0
selectNut      select SRRRS 000 000 1 00 4 000 0 0
selectPea      select SLS   000 000 1 00 1 000 0 0
selectSun      select SRS   000 000 1 00 2 000 0 0
selectBack     select SRRLS 000 000 1 00 2 000 0 0
pixelBar       pixel  -     190 064 1 00 0 0B4 0 0
pixelFrame     pixel  SR    0A2 032 1 00 0 F00 0 0
pixelBoxInside pixel  S     050 050 1 00 0 0B4 0 0
pixelGrid      pixel  -     014 0AA 1 00 0 392 0 0
pixelGreen     pixel  -     0C8 0AA 1 00 0 0F0 0 0
pixelDark      pixel  -     31F 0C8 0 00 0 000 0 0
gameWin        game   -     31F 0C8 1 1F 0 392 5 1
gamePartial    game   -     032 258 1 07 0 AAB 3 2
gameNoPeas     game   -     032 0C8 1 00 0 AAB 0 2
